// File: hdl/pad_cfg_pkg.sv
package pad_cfg_pkg;

   //////////////////////////////////////////////////
   // Register write fields
   //////////////////////////////////////////////////

   // Function select field
   localparam int unsigned PAD_FUNC_W = 2;

   // Electrical configuration word
   localparam int unsigned PAD_CFG_W = 6;

   //////////////////////////////////////////////////
   // Pad function select
   //////////////////////////////////////////////////

   typedef enum logic [PAD_FUNC_W-1:0] {
      // Pad owner peripheral
      FUNC_PERIPH = 2'b00,
      // GPIO bit with the pad index
      FUNC_GPIO   = 2'b01,
      // I2C1 on the alternate pads only
      FUNC_ALT    = 2'b10,
      // Pad parked, output disabled
      FUNC_NONE   = 2'b11
   } pad_func_e;

   // Drive strength, pulls and similar, passed on to the pad frame
   typedef logic [PAD_CFG_W-1:0] pad_cfg_t;

endpackage

// File: hdl/pad_map_pkg.sv
package pad_map_pkg;

   //////////////////////////////////////////////////
   // Pad frame size
   //////////////////////////////////////////////////

   localparam int unsigned NUM_PADS  = 11;

   // Also the width of the register write address
   localparam int unsigned PAD_IDX_W = 4;

   //////////////////////////////////////////////////
   // Pad indices, also the GPIO bit of each pad
   //////////////////////////////////////////////////

   localparam int unsigned PAD_SPIM_SDIO0 = 0;
   localparam int unsigned PAD_SPIM_SDIO1 = 1;
   localparam int unsigned PAD_SPIM_SDIO2 = 2;
   localparam int unsigned PAD_SPIM_SDIO3 = 3;
   localparam int unsigned PAD_SPIM_CSN0  = 4;
   localparam int unsigned PAD_SPIM_CSN1  = 5;
   localparam int unsigned PAD_SPIM_SCK   = 6;
   localparam int unsigned PAD_UART_RX    = 7;
   localparam int unsigned PAD_UART_TX    = 8;
   localparam int unsigned PAD_I2C0_SDA   = 9;
   localparam int unsigned PAD_I2C0_SCL   = 10;

   //////////////////////////////////////////////////
   // I2C1 alternate pads
   //////////////////////////////////////////////////

   // A side wins over B side on the input path
   localparam int unsigned PAD_ALT_SDA_A = 2;
   localparam int unsigned PAD_ALT_SDA_B = 7;
   localparam int unsigned PAD_ALT_SCL_A = 3;
   localparam int unsigned PAD_ALT_SCL_B = 8;

endpackage

// File: hdl/pad_ctrl_regs.sv
`timescale 1ns/1ps

module pad_ctrl_regs #(
   parameter pad_cfg_pkg::pad_cfg_t PAD_CFG_RST = '0
) (
   input  logic                                               clk_i,
   input  logic                                               rst_n_i,

   // Write strobe
   input  logic                                               cfg_we_i,
   input  logic [pad_map_pkg::PAD_IDX_W-1:0]                  cfg_addr_i,
   input  pad_cfg_pkg::pad_func_e                             cfg_func_i,
   input  pad_cfg_pkg::pad_cfg_t                              cfg_pad_i,

   // Per pad state
   output pad_cfg_pkg::pad_func_e [pad_map_pkg::NUM_PADS-1:0] pad_func_o,
   output pad_cfg_pkg::pad_cfg_t  [pad_map_pkg::NUM_PADS-1:0] pad_cfg_o
);

   logic addr_ok;

   // Writes beyond the last pad are dropped
   assign addr_ok = cfg_addr_i < pad_map_pkg::PAD_IDX_W'(pad_map_pkg::NUM_PADS);

   //////////////////////////////////////////////////
   // Function and configuration registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int p = 0; p < pad_map_pkg::NUM_PADS; p++) begin
            pad_func_o[p] <= pad_cfg_pkg::FUNC_NONE;
            pad_cfg_o[p]  <= PAD_CFG_RST;
         end
      end else if (cfg_we_i && addr_ok) begin
         pad_func_o[cfg_addr_i] <= cfg_func_i;
         pad_cfg_o[cfg_addr_i]  <= cfg_pad_i;
      end
   end

   // Host must only address existing pads
   a_addr_range: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      cfg_we_i |-> (cfg_addr_i < pad_map_pkg::PAD_IDX_W'(pad_map_pkg::NUM_PADS))
   ) else $error("pad_ctrl_regs: write to pad %0d out of range", cfg_addr_i);

endmodule

// File: hdl/pad_out_mux.sv
`timescale 1ns/1ps

module pad_out_mux (
   input  pad_cfg_pkg::pad_func_e [pad_map_pkg::NUM_PADS-1:0] pad_func_i,
   input  pad_cfg_pkg::pad_cfg_t  [pad_map_pkg::NUM_PADS-1:0] pad_cfg_i,

   // SPI master
   input  logic                                               spim_csn0_i,
   input  logic                                               spim_csn1_i,
   input  logic                                               spim_sck_i,
   input  logic [3:0]                                         spim_sdo_i,
   input  logic [3:0]                                         spim_oen_i,

   // UART
   input  logic                                               uart_tx_i,

   // I2C0
   input  logic                                               i2c0_sda_out_i,
   input  logic                                               i2c0_sda_oe_i,
   input  logic                                               i2c0_scl_out_i,
   input  logic                                               i2c0_scl_oe_i,

   // I2C1
   input  logic                                               i2c1_sda_out_i,
   input  logic                                               i2c1_sda_oe_i,
   input  logic                                               i2c1_scl_out_i,
   input  logic                                               i2c1_scl_oe_i,

   // GPIO
   input  logic [pad_map_pkg::NUM_PADS-1:0]                   gpio_out_i,
   input  logic [pad_map_pkg::NUM_PADS-1:0]                   gpio_dir_i,
   input  pad_cfg_pkg::pad_cfg_t  [pad_map_pkg::NUM_PADS-1:0] gpio_cfg_i,

   // Pad frame
   output logic [pad_map_pkg::NUM_PADS-1:0]                   pad_out_o,
   output logic [pad_map_pkg::NUM_PADS-1:0]                   pad_oe_o,
   output pad_cfg_pkg::pad_cfg_t  [pad_map_pkg::NUM_PADS-1:0] pad_cfg_o
);

   logic [pad_map_pkg::NUM_PADS-1:0] periph_out;
   logic [pad_map_pkg::NUM_PADS-1:0] periph_oe;
   logic [pad_map_pkg::NUM_PADS-1:0] alt_out;
   logic [pad_map_pkg::NUM_PADS-1:0] alt_oe;
   logic [pad_map_pkg::NUM_PADS-1:0] none_pads;

   //////////////////////////////////////////////////
   // Owner peripheral per pad
   //////////////////////////////////////////////////

   always_comb begin
      periph_out = '0;
      periph_oe  = '0;

      // SPI data, enables come in active low
      periph_out[pad_map_pkg::PAD_SPIM_SDIO0] = spim_sdo_i[0];
      periph_oe[pad_map_pkg::PAD_SPIM_SDIO0]  = ~spim_oen_i[0];
      periph_out[pad_map_pkg::PAD_SPIM_SDIO1] = spim_sdo_i[1];
      periph_oe[pad_map_pkg::PAD_SPIM_SDIO1]  = ~spim_oen_i[1];
      periph_out[pad_map_pkg::PAD_SPIM_SDIO2] = spim_sdo_i[2];
      periph_oe[pad_map_pkg::PAD_SPIM_SDIO2]  = ~spim_oen_i[2];
      periph_out[pad_map_pkg::PAD_SPIM_SDIO3] = spim_sdo_i[3];
      periph_oe[pad_map_pkg::PAD_SPIM_SDIO3]  = ~spim_oen_i[3];

      periph_out[pad_map_pkg::PAD_SPIM_CSN0]  = spim_csn0_i;
      periph_oe[pad_map_pkg::PAD_SPIM_CSN0]   = 1'b1;
      periph_out[pad_map_pkg::PAD_SPIM_CSN1]  = spim_csn1_i;
      periph_oe[pad_map_pkg::PAD_SPIM_CSN1]   = 1'b1;
      periph_out[pad_map_pkg::PAD_SPIM_SCK]   = spim_sck_i;
      periph_oe[pad_map_pkg::PAD_SPIM_SCK]    = 1'b1;

      // Input only
      periph_out[pad_map_pkg::PAD_UART_RX]    = 1'b0;
      periph_oe[pad_map_pkg::PAD_UART_RX]     = 1'b0;
      periph_out[pad_map_pkg::PAD_UART_TX]    = uart_tx_i;
      periph_oe[pad_map_pkg::PAD_UART_TX]     = 1'b1;

      periph_out[pad_map_pkg::PAD_I2C0_SDA]   = i2c0_sda_out_i;
      periph_oe[pad_map_pkg::PAD_I2C0_SDA]    = i2c0_sda_oe_i;
      periph_out[pad_map_pkg::PAD_I2C0_SCL]   = i2c0_scl_out_i;
      periph_oe[pad_map_pkg::PAD_I2C0_SCL]    = i2c0_scl_oe_i;
   end

   // I2C1 shows up on two pad pairs, the rest stay parked
   always_comb begin
      alt_out = '0;
      alt_oe  = '0;
      alt_out[pad_map_pkg::PAD_ALT_SDA_A] = i2c1_sda_out_i;
      alt_oe[pad_map_pkg::PAD_ALT_SDA_A]  = i2c1_sda_oe_i;
      alt_out[pad_map_pkg::PAD_ALT_SDA_B] = i2c1_sda_out_i;
      alt_oe[pad_map_pkg::PAD_ALT_SDA_B]  = i2c1_sda_oe_i;
      alt_out[pad_map_pkg::PAD_ALT_SCL_A] = i2c1_scl_out_i;
      alt_oe[pad_map_pkg::PAD_ALT_SCL_A]  = i2c1_scl_oe_i;
      alt_out[pad_map_pkg::PAD_ALT_SCL_B] = i2c1_scl_out_i;
      alt_oe[pad_map_pkg::PAD_ALT_SCL_B]  = i2c1_scl_oe_i;
   end

   //////////////////////////////////////////////////
   // Function select
   //////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < pad_map_pkg::NUM_PADS; p++) begin
         pad_out_o[p] = 1'b0;
         pad_oe_o[p]  = 1'b0;
         pad_cfg_o[p] = pad_cfg_i[p];
         case (pad_func_i[p])
            pad_cfg_pkg::FUNC_PERIPH: begin
               pad_out_o[p] = periph_out[p];
               pad_oe_o[p]  = periph_oe[p];
            end
            pad_cfg_pkg::FUNC_GPIO: begin
               pad_out_o[p] = gpio_out_i[p];
               pad_oe_o[p]  = gpio_dir_i[p];
               // GPIO block owns the electrical setup
               pad_cfg_o[p] = gpio_cfg_i[p];
            end
            pad_cfg_pkg::FUNC_ALT: begin
               pad_out_o[p] = alt_out[p];
               pad_oe_o[p]  = alt_oe[p];
            end
            default: begin
               pad_out_o[p] = 1'b0;
               pad_oe_o[p]  = 1'b0;
            end
         endcase
      end
   end

   // Parked pads never drive the pad frame
   always_comb begin
      for (int p = 0; p < pad_map_pkg::NUM_PADS; p++) begin
         none_pads[p] = (pad_func_i[p] == pad_cfg_pkg::FUNC_NONE);
      end
      a_none_no_oe: assert final ((pad_oe_o & none_pads) == '0)
         else $error("pad_out_mux: parked pad enabled, oe %h", pad_oe_o);
   end

endmodule

// File: hdl/pad_in_route.sv
`timescale 1ns/1ps

module pad_in_route (
   input  pad_cfg_pkg::pad_func_e [pad_map_pkg::NUM_PADS-1:0] pad_func_i,
   input  logic [pad_map_pkg::NUM_PADS-1:0]                   pad_in_i,

   output logic [3:0]                                         spim_sdi_o,
   output logic                                               uart_rx_o,
   output logic                                               i2c0_sda_in_o,
   output logic                                               i2c0_scl_in_o,
   output logic                                               i2c1_sda_in_o,
   output logic                                               i2c1_scl_in_o,
   output logic [pad_map_pkg::NUM_PADS-1:0]                   gpio_in_o
);

   logic [pad_map_pkg::NUM_PADS-1:0] is_periph;
   logic [pad_map_pkg::NUM_PADS-1:0] is_gpio;
   logic [pad_map_pkg::NUM_PADS-1:0] is_alt;

   always_comb begin
      for (int p = 0; p < pad_map_pkg::NUM_PADS; p++) begin
         is_periph[p] = (pad_func_i[p] == pad_cfg_pkg::FUNC_PERIPH);
         is_gpio[p]   = (pad_func_i[p] == pad_cfg_pkg::FUNC_GPIO);
         is_alt[p]    = (pad_func_i[p] == pad_cfg_pkg::FUNC_ALT);
      end
   end

   //////////////////////////////////////////////////
   // Peripheral inputs, idle value when not selected
   //////////////////////////////////////////////////

   // SPI data idles low
   assign spim_sdi_o[0] = is_periph[pad_map_pkg::PAD_SPIM_SDIO0] ?
                          pad_in_i[pad_map_pkg::PAD_SPIM_SDIO0] : 1'b0;
   assign spim_sdi_o[1] = is_periph[pad_map_pkg::PAD_SPIM_SDIO1] ?
                          pad_in_i[pad_map_pkg::PAD_SPIM_SDIO1] : 1'b0;
   assign spim_sdi_o[2] = is_periph[pad_map_pkg::PAD_SPIM_SDIO2] ?
                          pad_in_i[pad_map_pkg::PAD_SPIM_SDIO2] : 1'b0;
   assign spim_sdi_o[3] = is_periph[pad_map_pkg::PAD_SPIM_SDIO3] ?
                          pad_in_i[pad_map_pkg::PAD_SPIM_SDIO3] : 1'b0;

   // UART and I2C idle high, like an undriven line with pull-up
   assign uart_rx_o     = is_periph[pad_map_pkg::PAD_UART_RX] ?
                          pad_in_i[pad_map_pkg::PAD_UART_RX] : 1'b1;
   assign i2c0_sda_in_o = is_periph[pad_map_pkg::PAD_I2C0_SDA] ?
                          pad_in_i[pad_map_pkg::PAD_I2C0_SDA] : 1'b1;
   assign i2c0_scl_in_o = is_periph[pad_map_pkg::PAD_I2C0_SCL] ?
                          pad_in_i[pad_map_pkg::PAD_I2C0_SCL] : 1'b1;

   // A pad first, then B pad
   assign i2c1_sda_in_o = is_alt[pad_map_pkg::PAD_ALT_SDA_A] ? pad_in_i[pad_map_pkg::PAD_ALT_SDA_A] :
                          is_alt[pad_map_pkg::PAD_ALT_SDA_B] ? pad_in_i[pad_map_pkg::PAD_ALT_SDA_B] :
                          1'b1;
   assign i2c1_scl_in_o = is_alt[pad_map_pkg::PAD_ALT_SCL_A] ? pad_in_i[pad_map_pkg::PAD_ALT_SCL_A] :
                          is_alt[pad_map_pkg::PAD_ALT_SCL_B] ? pad_in_i[pad_map_pkg::PAD_ALT_SCL_B] :
                          1'b1;

   assign gpio_in_o = pad_in_i & is_gpio;

   // GPIO must not see pads owned by someone else
   always_comb begin
      for (int p = 0; p < pad_map_pkg::NUM_PADS; p++) begin
         a_gpio_isolated: assert final (
            (pad_func_i[p] == pad_cfg_pkg::FUNC_GPIO) || (gpio_in_o[p] == 1'b0)
         ) else $error("pad_in_route: gpio input leak on pad %0d", p);
      end
   end

endmodule

// File: hdl/pad_ctrl_top.sv
`timescale 1ns/1ps

module pad_ctrl_top #(
   parameter pad_cfg_pkg::pad_cfg_t PAD_CFG_RST = '0
) (
   input  logic                                               clk_i,
   input  logic                                               rst_n_i,

   // Pad control register write
   input  logic                                               cfg_we_i,
   input  logic [pad_map_pkg::PAD_IDX_W-1:0]                  cfg_addr_i,
   input  pad_cfg_pkg::pad_func_e                             cfg_func_i,
   input  pad_cfg_pkg::pad_cfg_t                              cfg_pad_i,

   // SPI master
   input  logic                                               spim_csn0_i,
   input  logic                                               spim_csn1_i,
   input  logic                                               spim_sck_i,
   input  logic [3:0]                                         spim_sdo_i,
   input  logic [3:0]                                         spim_oen_i,
   output logic [3:0]                                         spim_sdi_o,

   // UART
   input  logic                                               uart_tx_i,
   output logic                                               uart_rx_o,

   // I2C0
   input  logic                                               i2c0_sda_out_i,
   input  logic                                               i2c0_sda_oe_i,
   input  logic                                               i2c0_scl_out_i,
   input  logic                                               i2c0_scl_oe_i,
   output logic                                               i2c0_sda_in_o,
   output logic                                               i2c0_scl_in_o,

   // I2C1
   input  logic                                               i2c1_sda_out_i,
   input  logic                                               i2c1_sda_oe_i,
   input  logic                                               i2c1_scl_out_i,
   input  logic                                               i2c1_scl_oe_i,
   output logic                                               i2c1_sda_in_o,
   output logic                                               i2c1_scl_in_o,

   // GPIO
   input  logic [pad_map_pkg::NUM_PADS-1:0]                   gpio_out_i,
   input  logic [pad_map_pkg::NUM_PADS-1:0]                   gpio_dir_i,
   input  pad_cfg_pkg::pad_cfg_t  [pad_map_pkg::NUM_PADS-1:0] gpio_cfg_i,
   output logic [pad_map_pkg::NUM_PADS-1:0]                   gpio_in_o,

   // Pad frame
   input  logic [pad_map_pkg::NUM_PADS-1:0]                   pad_in_i,
   output logic [pad_map_pkg::NUM_PADS-1:0]                   pad_out_o,
   output logic [pad_map_pkg::NUM_PADS-1:0]                   pad_oe_o,
   output pad_cfg_pkg::pad_cfg_t  [pad_map_pkg::NUM_PADS-1:0] pad_cfg_o
);

   pad_cfg_pkg::pad_func_e [pad_map_pkg::NUM_PADS-1:0] pad_func;
   pad_cfg_pkg::pad_cfg_t  [pad_map_pkg::NUM_PADS-1:0] pad_cfg;

   //////////////////////////////////////////////////
   // Pad control registers
   //////////////////////////////////////////////////

   pad_ctrl_regs #(
      .PAD_CFG_RST (PAD_CFG_RST)
   ) u_regs (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .cfg_we_i   (cfg_we_i),
      .cfg_addr_i (cfg_addr_i),
      .cfg_func_i (cfg_func_i),
      .cfg_pad_i  (cfg_pad_i),
      .pad_func_o (pad_func),
      .pad_cfg_o  (pad_cfg)
   );

   //////////////////////////////////////////////////
   // Outward and inward paths
   //////////////////////////////////////////////////

   pad_out_mux u_out_mux (
      .pad_func_i     (pad_func),
      .pad_cfg_i      (pad_cfg),
      .spim_csn0_i    (spim_csn0_i),
      .spim_csn1_i    (spim_csn1_i),
      .spim_sck_i     (spim_sck_i),
      .spim_sdo_i     (spim_sdo_i),
      .spim_oen_i     (spim_oen_i),
      .uart_tx_i      (uart_tx_i),
      .i2c0_sda_out_i (i2c0_sda_out_i),
      .i2c0_sda_oe_i  (i2c0_sda_oe_i),
      .i2c0_scl_out_i (i2c0_scl_out_i),
      .i2c0_scl_oe_i  (i2c0_scl_oe_i),
      .i2c1_sda_out_i (i2c1_sda_out_i),
      .i2c1_sda_oe_i  (i2c1_sda_oe_i),
      .i2c1_scl_out_i (i2c1_scl_out_i),
      .i2c1_scl_oe_i  (i2c1_scl_oe_i),
      .gpio_out_i     (gpio_out_i),
      .gpio_dir_i     (gpio_dir_i),
      .gpio_cfg_i     (gpio_cfg_i),
      .pad_out_o      (pad_out_o),
      .pad_oe_o       (pad_oe_o),
      .pad_cfg_o      (pad_cfg_o)
   );

   pad_in_route u_in_route (
      .pad_func_i    (pad_func),
      .pad_in_i      (pad_in_i),
      .spim_sdi_o    (spim_sdi_o),
      .uart_rx_o     (uart_rx_o),
      .i2c0_sda_in_o (i2c0_sda_in_o),
      .i2c0_scl_in_o (i2c0_scl_in_o),
      .i2c1_sda_in_o (i2c1_sda_in_o),
      .i2c1_scl_in_o (i2c1_scl_in_o),
      .gpio_in_o     (gpio_in_o)
   );

endmodule

// File: testbench/pad_ctrl_tb.sv
`timescale 1ns/1ps

module pad_ctrl_tb;

   localparam int NP            = pad_map_pkg::NUM_PADS;
   localparam int STEPS         = 6;
   localparam int WRITE_TIMEOUT = 4;
   localparam int NUM_ENTRIES   = 31;
   localparam pad_cfg_pkg::pad_cfg_t CFG_RST = 6'h2D;

   localparam logic [1:0] F_PER  = pad_cfg_pkg::FUNC_PERIPH;
   localparam logic [1:0] F_GPIO = pad_cfg_pkg::FUNC_GPIO;
   localparam logic [1:0] F_ALT  = pad_cfg_pkg::FUNC_ALT;
   localparam logic [1:0] F_NONE = pad_cfg_pkg::FUNC_NONE;

   // Entry is {pad, function, configuration word}
   localparam logic [11:0] WR_TABLE [NUM_ENTRIES] = '{
      // Every pad on its own peripheral
      {4'd0, F_PER, 6'h01}, {4'd1, F_PER, 6'h02}, {4'd2, F_PER, 6'h03}, {4'd3, F_PER, 6'h04},
      {4'd4, F_PER, 6'h05}, {4'd5, F_PER, 6'h06}, {4'd6, F_PER, 6'h07}, {4'd7, F_PER, 6'h08},
      {4'd8, F_PER, 6'h09}, {4'd9, F_PER, 6'h0A}, {4'd10, F_PER, 6'h0B},
      // GPIO takeover
      {4'd0, F_GPIO, 6'h11}, {4'd5, F_GPIO, 6'h12}, {4'd9, F_GPIO, 6'h13}, {4'd10, F_GPIO, 6'h14},
      // I2C1 on both pairs, then one side of each pair dropped
      {4'd2, F_ALT, 6'h21}, {4'd7, F_ALT, 6'h22}, {4'd8, F_ALT, 6'h23}, {4'd3, F_ALT, 6'h24},
      {4'd4, F_ALT, 6'h25}, {4'd2, F_NONE, 6'h26}, {4'd3, F_GPIO, 6'h27}, {4'd0, F_ALT, 6'h28},
      // Park again
      {4'd7, F_NONE, 6'h31}, {4'd8, F_NONE, 6'h32}, {4'd9, F_NONE, 6'h33}, {4'd1, F_NONE, 6'h34},
      {4'd6, F_NONE, 6'h35}, {4'd4, F_PER, 6'h36}, {4'd4, F_NONE, 6'h37}, {4'd10, F_NONE, 6'h3F}
   };

   logic clk_i, rst_n_i, cfg_we_i;
   logic [pad_map_pkg::PAD_IDX_W-1:0] cfg_addr_i;
   pad_cfg_pkg::pad_func_e cfg_func_i;
   pad_cfg_pkg::pad_cfg_t cfg_pad_i;
   logic spim_csn0_i, spim_csn1_i, spim_sck_i, uart_tx_i;
   logic [3:0] spim_sdo_i, spim_oen_i, spim_sdi_o;
   logic i2c0_sda_out_i, i2c0_sda_oe_i, i2c0_scl_out_i, i2c0_scl_oe_i;
   logic i2c1_sda_out_i, i2c1_sda_oe_i, i2c1_scl_out_i, i2c1_scl_oe_i;
   logic uart_rx_o, i2c0_sda_in_o, i2c0_scl_in_o, i2c1_sda_in_o, i2c1_scl_in_o;
   logic [NP-1:0] gpio_out_i, gpio_dir_i, gpio_in_o, pad_in_i, pad_out_o, pad_oe_o;
   pad_cfg_pkg::pad_cfg_t [NP-1:0] gpio_cfg_i, pad_cfg_o;

   // Reference model state and expected values
   pad_cfg_pkg::pad_func_e model_func [NP];
   pad_cfg_pkg::pad_cfg_t model_cfg [NP];
   logic [NP-1:0] exp_out, exp_oe, exp_gpio_in, periph_out, periph_oe, alt_out, alt_oe;
   pad_cfg_pkg::pad_cfg_t [NP-1:0] exp_cfg;
   logic [3:0] exp_sdi;
   logic exp_uart_rx, exp_i2c0_sda, exp_i2c0_scl, exp_i2c1_sda, exp_i2c1_scl;
   logic [107:0] exp_all;
   wire [107:0] got_all;

   logic [15:0] lfsr;
   int mismatches, failures;
   bit hung;
   string phase;

   pad_ctrl_top #(.PAD_CFG_RST(CFG_RST)) uut (.*);

   assign got_all = {pad_out_o, pad_oe_o, pad_cfg_o, gpio_in_o, spim_sdi_o, uart_rx_o,
                     i2c0_sda_in_o, i2c0_scl_in_o, i2c1_sda_in_o, i2c1_scl_in_o};

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////
   // Stimulus source
   //////////////////////////////////////////////////

   // 16 bit Fibonacci, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [79:0] rand_bits(input int n);
      logic [79:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[78:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic drive_random();
      logic [79:0] r;
      r = rand_bits(20);
      {spim_csn0_i, spim_csn1_i, spim_sck_i, uart_tx_i, spim_sdo_i, spim_oen_i} <= r[11:0];
      {i2c0_sda_out_i, i2c0_sda_oe_i, i2c0_scl_out_i, i2c0_scl_oe_i} <= r[15:12];
      {i2c1_sda_out_i, i2c1_sda_oe_i, i2c1_scl_out_i, i2c1_scl_oe_i} <= r[19:16];
      r = rand_bits(33);
      {gpio_out_i, gpio_dir_i, pad_in_i} <= r[32:0];
      r = rand_bits(66);
      gpio_cfg_i <= r[65:0];
   endtask

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic logic pad_or_idle(input int pad, input pad_cfg_pkg::pad_func_e f,
                                        input logic idle);
      return (model_func[pad] == f) ? pad_in_i[pad] : idle;
   endfunction

   function automatic void compute_expected();
      // Ordered from pad 10 down to pad 0
      periph_out = {i2c0_scl_out_i, i2c0_sda_out_i, uart_tx_i, 1'b0, spim_sck_i, spim_csn1_i,
                    spim_csn0_i, spim_sdo_i};
      periph_oe  = {i2c0_scl_oe_i, i2c0_sda_oe_i, 1'b1, 1'b0, 3'b111, ~spim_oen_i};
      // Pads 8 and 7 are the B side of I2C1, pads 3 and 2 the A side
      alt_out = {2'b00, i2c1_scl_out_i, i2c1_sda_out_i, 3'b000, i2c1_scl_out_i,
                 i2c1_sda_out_i, 2'b00};
      alt_oe  = {2'b00, i2c1_scl_oe_i, i2c1_sda_oe_i, 3'b000, i2c1_scl_oe_i,
                 i2c1_sda_oe_i, 2'b00};
      for (int p = 0; p < NP; p++) begin
         exp_cfg[p]     = (model_func[p] == pad_cfg_pkg::FUNC_GPIO) ? gpio_cfg_i[p] : model_cfg[p];
         exp_gpio_in[p] = pad_or_idle(p, pad_cfg_pkg::FUNC_GPIO, 1'b0);
         case (model_func[p])
            pad_cfg_pkg::FUNC_PERIPH: {exp_out[p], exp_oe[p]} = {periph_out[p], periph_oe[p]};
            pad_cfg_pkg::FUNC_GPIO:   {exp_out[p], exp_oe[p]} = {gpio_out_i[p], gpio_dir_i[p]};
            pad_cfg_pkg::FUNC_ALT:    {exp_out[p], exp_oe[p]} = {alt_out[p], alt_oe[p]};
            default:                  {exp_out[p], exp_oe[p]} = 2'b00;
         endcase
      end
      for (int n = 0; n < 4; n++)
         exp_sdi[n] = pad_or_idle(n, pad_cfg_pkg::FUNC_PERIPH, 1'b0);
      exp_uart_rx  = pad_or_idle(pad_map_pkg::PAD_UART_RX, pad_cfg_pkg::FUNC_PERIPH, 1'b1);
      exp_i2c0_sda = pad_or_idle(pad_map_pkg::PAD_I2C0_SDA, pad_cfg_pkg::FUNC_PERIPH, 1'b1);
      exp_i2c0_scl = pad_or_idle(pad_map_pkg::PAD_I2C0_SCL, pad_cfg_pkg::FUNC_PERIPH, 1'b1);
      // A pad has priority over B pad
      exp_i2c1_sda = pad_or_idle(pad_map_pkg::PAD_ALT_SDA_A, pad_cfg_pkg::FUNC_ALT,
                        pad_or_idle(pad_map_pkg::PAD_ALT_SDA_B, pad_cfg_pkg::FUNC_ALT, 1'b1));
      exp_i2c1_scl = pad_or_idle(pad_map_pkg::PAD_ALT_SCL_A, pad_cfg_pkg::FUNC_ALT,
                        pad_or_idle(pad_map_pkg::PAD_ALT_SCL_B, pad_cfg_pkg::FUNC_ALT, 1'b1));
      exp_all = {exp_out, exp_oe, exp_cfg, exp_gpio_in, exp_sdi, exp_uart_rx,
                 exp_i2c0_sda, exp_i2c0_scl, exp_i2c1_sda, exp_i2c1_scl};
   endfunction

   //////////////////////////////////////////////////
   // Checking
   //////////////////////////////////////////////////

   task automatic mismatch(input string name, input logic [79:0] got, input logic [79:0] exp);
      mismatches++;
      $display("MISMATCH %s at %s: got %0h expected %0h", name, phase, got, exp);
   endtask

   task automatic check_outputs();
      if (pad_out_o !== exp_out) mismatch("pad_out_o", 80'(pad_out_o), 80'(exp_out));
      if (pad_oe_o !== exp_oe) mismatch("pad_oe_o", 80'(pad_oe_o), 80'(exp_oe));
      if (pad_cfg_o !== exp_cfg) mismatch("pad_cfg_o", 80'(pad_cfg_o), 80'(exp_cfg));
      if (gpio_in_o !== exp_gpio_in) mismatch("gpio_in_o", 80'(gpio_in_o), 80'(exp_gpio_in));
      if (spim_sdi_o !== exp_sdi) mismatch("spim_sdi_o", 80'(spim_sdi_o), 80'(exp_sdi));
      if (uart_rx_o !== exp_uart_rx) mismatch("uart_rx_o", 80'(uart_rx_o), 80'(exp_uart_rx));
      if (i2c0_sda_in_o !== exp_i2c0_sda)
         mismatch("i2c0_sda_in_o", 80'(i2c0_sda_in_o), 80'(exp_i2c0_sda));
      if (i2c0_scl_in_o !== exp_i2c0_scl)
         mismatch("i2c0_scl_in_o", 80'(i2c0_scl_in_o), 80'(exp_i2c0_scl));
      if (i2c1_sda_in_o !== exp_i2c1_sda)
         mismatch("i2c1_sda_in_o", 80'(i2c1_sda_in_o), 80'(exp_i2c1_sda));
      if (i2c1_scl_in_o !== exp_i2c1_scl)
         mismatch("i2c1_scl_in_o", 80'(i2c1_scl_in_o), 80'(exp_i2c1_scl));
   endtask

   task automatic random_steps(input string tag);
      for (int s = 0; s < STEPS; s++) begin
         @(posedge clk_i);
         drive_random();
         @(negedge clk_i);
         phase = $sformatf("%s step %0d", tag, s);
         compute_expected();
         check_outputs();
      end
   endtask

   task automatic apply_write(input int i);
      logic [11:0] e;
      int cycles;
      bit landed;
      e = WR_TABLE[i];
      @(posedge clk_i);
      cfg_we_i   <= 1'b1;
      cfg_addr_i <= e[11:8];
      cfg_func_i <= pad_cfg_pkg::pad_func_e'(e[7:6]);
      cfg_pad_i  <= e[5:0];
      // Strobe presented, registers still hold the old state
      @(negedge clk_i);
      phase = $sformatf("entry %0d before write", i);
      compute_expected();
      check_outputs();
      @(posedge clk_i);
      cfg_we_i <= 1'b0;
      model_func[e[11:8]] = pad_cfg_pkg::pad_func_e'(e[7:6]);
      model_cfg[e[11:8]]  = e[5:0];
      compute_expected();
      phase = $sformatf("entry %0d write to pad %0d", i, e[11:8]);
      cycles = 0;
      landed = 1'b0;
      while (!landed && cycles < WRITE_TIMEOUT) begin
         @(negedge clk_i);
         cycles++;
         landed = (got_all === exp_all);
      end
      if (!landed) begin
         failures++;
         hung = 1'b1;
         $display("Timeout: write of entry %0d never reached the pad outputs", i);
      end else if (cycles != 1) begin
         failures++;
         $display("Write of entry %0d took %0d cycles to show instead of one", i, cycles);
      end
      check_outputs();
   endtask

   initial begin
      lfsr       = 16'd41584;
      mismatches = 0;
      failures   = 0;
      hung       = 1'b0;
      rst_n_i    <= 1'b0;
      cfg_we_i   <= 1'b0;
      cfg_addr_i <= '0;
      cfg_func_i <= pad_cfg_pkg::FUNC_NONE;
      cfg_pad_i  <= '0;
      {spim_csn0_i, spim_csn1_i, spim_sck_i, uart_tx_i, spim_sdo_i, spim_oen_i} <= 12'h0;
      {i2c0_sda_out_i, i2c0_sda_oe_i, i2c0_scl_out_i, i2c0_scl_oe_i} <= 4'h0;
      {i2c1_sda_out_i, i2c1_sda_oe_i, i2c1_scl_out_i, i2c1_scl_oe_i} <= 4'h0;
      {gpio_out_i, gpio_dir_i, pad_in_i} <= 33'h0;
      gpio_cfg_i <= '0;
      for (int p = 0; p < NP; p++) begin
         model_func[p] = pad_cfg_pkg::FUNC_NONE;
         model_cfg[p]  = CFG_RST;
      end
      for (int c = 0; c < 16; c++)
         @(posedge clk_i);
      rst_n_i <= 1'b1;
      random_steps("after reset");
      for (int i = 0; i < NUM_ENTRIES && !hung; i++) begin
         apply_write(i);
         random_steps($sformatf("entry %0d", i));
      end
      $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: pad_ctrl.f
hdl/pad_cfg_pkg.sv
hdl/pad_map_pkg.sv
hdl/pad_ctrl_regs.sv
hdl/pad_out_mux.sv
hdl/pad_in_route.sv
hdl/pad_ctrl_top.sv
testbench/pad_ctrl_tb.sv

// File: Makefile
SIM = obj_dir/pad_ctrl_sim

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -sv -f pad_ctrl.f --top-module pad_ctrl_tb -Mdir obj_dir -o pad_ctrl_sim

run: build
	$(SIM) | tee sim.log
	grep -q "^Everything OK$$" sim.log

lint:
	verilator --lint-only -Wall -sv -f pad_ctrl.f --top-module pad_ctrl_top

clean:
	rm -rf obj_dir sim.log
